// File: common/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word; // one instruction word
	typedef logic [3:0] lc3b_opcode; // bits 15:12
	typedef logic [2:0] lc3b_reg; // register index
	typedef logic [2:0] shadow_count; // control-flow shadow countdown

	// standard lc3b opcode map
	localparam lc3b_opcode op_br = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_ldb = 4'b0010;
	localparam lc3b_opcode op_stb = 4'b0011;
	localparam lc3b_opcode op_jsr = 4'b0100; // also jsrr when bit 11 clear
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_ldi = 4'b1010;
	localparam lc3b_opcode op_sti = 4'b1011;
	localparam lc3b_opcode op_jmp = 4'b1100; // ret is jmp r7
	localparam lc3b_opcode op_shf = 4'b1101;
	localparam lc3b_opcode op_lea = 4'b1110;
	localparam lc3b_opcode op_trap = 4'b1111;

	localparam int op_lsb = 12; // opcode field 15:12
	localparam int dr_lsb = 9; // dest, or store source, 11:9
	localparam int sr1_lsb = 6; // sr1 or base 8:6
	localparam int sr2_lsb = 0; // sr2 2:0
	localparam int imm_bit = 5; // add/and immediate select
	localparam int jsr_bit = 11; // jsr offset form when set

	localparam shadow_count shadow_len = 3'd5; // four bubbles then the resolve cycle
	localparam lc3b_word nop_word = 16'h0000; // br with no condition bits

	function automatic lc3b_opcode opcode_of(input lc3b_word w);
		return w[op_lsb +: 4];
	endfunction

	function automatic lc3b_reg dr_of(input lc3b_word w);
		return w[dr_lsb +: 3];
	endfunction

	function automatic lc3b_reg sr1_of(input lc3b_word w);
		return w[sr1_lsb +: 3];
	endfunction

	function automatic lc3b_reg sr2_of(input lc3b_word w);
		return w[sr2_lsb +: 3];
	endfunction

endpackage

`default_nettype wire

// File: common/hazard_if.sv
`default_nettype none

interface hazard_if;

	import lc3b_pkg::*;

	lc3b_word if_id_ir; // word sitting in if/id
	lc3b_word id_ex_ir; // word sitting in id/ex
	logic flow_id_ex; // pipeline advancing this cycle (not held)
	logic gen_bubble; // freeze if/id, push nop into id/ex
	logic squash_id; // replace the if/id word by a nop on its way to id/ex

	modport pipe
	(
		output if_id_ir,
		output id_ex_ir,
		output flow_id_ex,
		input gen_bubble,
		input squash_id
	);

	modport hazard
	(
		input if_id_ir,
		input id_ex_ir,
		input flow_id_ex,
		output gen_bubble,
		output squash_id
	);

endinterface

`default_nettype wire

// File: hazard/dependency_decode.sv
`default_nettype none

module dependency_decode
(
	input lc3b_pkg::lc3b_word ir,
	output logic produces_dr, // writes the 11:9 register
	output logic need_sr1, // reads 8:6
	output logic need_sr2, // reads 2:0
	output logic need_hsr // store, 11:9 is a source
);

	import lc3b_pkg::*;

	lc3b_opcode opcode;

	assign opcode = opcode_of(ir);

	always_comb
	begin
		produces_dr = 1'b0;
		need_sr1 = 1'b0;
		need_sr2 = 1'b0;
		need_hsr = 1'b0;
		unique case (opcode)
			op_add, op_and:
			begin
				produces_dr = 1'b1;
				need_sr1 = 1'b1;
				need_sr2 = !ir[imm_bit]; // register form only
			end
			op_not, op_shf:
			begin
				produces_dr = 1'b1;
				need_sr1 = 1'b1;
			end
			op_ldb, op_ldr, op_ldi:
			begin
				produces_dr = 1'b1;
				need_sr1 = 1'b1; // base register
			end
			op_stb, op_str, op_sti:
			begin
				need_sr1 = 1'b1; // base register
				need_hsr = 1'b1; // data register in 11:9
			end
			op_lea: produces_dr = 1'b1; // pc relative, no source
			op_jmp: need_sr1 = 1'b1; // target base
			op_jsr: need_sr1 = !ir[jsr_bit]; // jsrr reads its base
			default:
			begin
				// br, trap and rti name no general register in these fields
				produces_dr = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hazard/bubbler.sv
`default_nettype none

module bubbler
(
	input logic clk,
	input logic rst,
	input logic branch_enable, // condition outcome from execute
	hazard_if.hazard hz
);

	import lc3b_pkg::*;

	logic ifid_sr1; // if/id dependency flags
	logic ifid_sr2;
	logic ifid_hsr;
	logic idex_dr; // id/ex writes its 11:9 register
	logic idex_load; // id/ex holds a load
	logic load_use; // one-cycle load-use stall
	logic is_flow; // if/id is a pc-changing instruction

	shadow_count count; // shadow countdown, zero when idle
	shadow_count count_next;
	logic capture; // grab the control word into captured
	logic shadow_bubble;
	logic squash;
	logic be_latched; // branch enable seen while advancing
	lc3b_word captured; // control word that opened the shadow

	dependency_decode i_ifid_deps
	(
		.ir(hz.if_id_ir),
		.produces_dr(),
		.need_sr1(ifid_sr1),
		.need_sr2(ifid_sr2),
		.need_hsr(ifid_hsr)
	);

	dependency_decode i_idex_deps
	(
		.ir(hz.id_ex_ir),
		.produces_dr(idex_dr),
		.need_sr1(),
		.need_sr2(),
		.need_hsr()
	);

	assign idex_load = idex_dr && ((opcode_of(hz.id_ex_ir) == op_ldb) ||
		(opcode_of(hz.id_ex_ir) == op_ldr) || (opcode_of(hz.id_ex_ir) == op_ldi));

	// load result is not ready for the next instruction, one bubble covers it
	always_comb
	begin
		load_use = 1'b0;
		if (idex_load)
		begin
			if (ifid_hsr && ((dr_of(hz.if_id_ir) == dr_of(hz.id_ex_ir)) ||
				(sr1_of(hz.if_id_ir) == dr_of(hz.id_ex_ir))))
				load_use = 1'b1; // store data or base
			if (ifid_sr1 && (sr1_of(hz.if_id_ir) == dr_of(hz.id_ex_ir)))
				load_use = 1'b1;
			if (ifid_sr2 && (sr2_of(hz.if_id_ir) == dr_of(hz.id_ex_ir)))
				load_use = 1'b1;
		end
	end

	assign is_flow = (opcode_of(hz.if_id_ir) == op_br) || (opcode_of(hz.if_id_ir) == op_jmp) ||
		(opcode_of(hz.if_id_ir) == op_jsr) || (opcode_of(hz.if_id_ir) == op_trap) ||
		(opcode_of(hz.if_id_ir) == op_lea);

	always_comb
	begin
		count_next = count;
		capture = 1'b0;
		shadow_bubble = 1'b0;
		squash = 1'b0;
		if ((count == 3'd0) && (hz.if_id_ir != nop_word) && is_flow)
		begin
			count_next = shadow_len; // open the shadow
			capture = 1'b1;
		end
		else if (count > 3'd1)
		begin
			count_next = count - 3'd1;
			shadow_bubble = 1'b1; // hold fall-through in if/id
		end
		else if (count == 3'd1)
		begin
			count_next = count - 3'd1; // resolve cycle
			unique case (opcode_of(captured))
				op_br: squash = be_latched; // taken branch drops fall-through
				op_lea: squash = 1'b0; // lea never redirects
				default: squash = 1'b1; // jmp, jsr, trap always redirect
			endcase
		end
	end

	assign hz.gen_bubble = load_use | shadow_bubble;
	assign hz.squash_id = squash;

	// counter ignores hold on purpose, it tracks cycles not instructions
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= '0;
			be_latched <= 1'b0;
		end
		else
		begin
			count <= count_next;
			if (hz.flow_id_ex)
				be_latched <= branch_enable; // sample only when moving
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			captured <= hz.if_id_ir; // read only at the resolve cycle
	end

endmodule

`default_nettype wire

// File: source/pipeline_front.sv
`default_nettype none

module pipeline_front
(
	input logic clk,
	input logic rst,
	input logic hold, // downstream freeze
	input lc3b_pkg::lc3b_word fetch_ir, // word offered by fetch
	output logic fetch_take, // fetch_ir consumed at this edge
	hazard_if.pipe hz
);

	import lc3b_pkg::*;

	logic advance; // pipeline moves this edge
	logic if_id_load; // if/id takes the fetch word
	lc3b_word id_ex_next; // what id/ex loads when advancing

	assign advance = !hold;
	assign hz.flow_id_ex = advance;

	// a bubble keeps if/id and feeds a nop forward
	assign if_id_load = advance && !hz.gen_bubble;
	assign fetch_take = if_id_load;

	always_comb
	begin
		if (hz.gen_bubble)
			id_ex_next = nop_word; // bubble
		else if (hz.squash_id)
			id_ex_next = nop_word; // squashed fall-through
		else
			id_ex_next = hz.if_id_ir;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			hz.if_id_ir <= nop_word;
		else if (if_id_load)
			hz.if_id_ir <= fetch_ir;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			hz.id_ex_ir <= nop_word;
		else if (advance)
			hz.id_ex_ir <= id_ex_next; // held words stay put
	end

endmodule

`default_nettype wire

// File: source/lc3b_hazard_top.sv
`default_nettype none

module lc3b_hazard_top
(
	input logic clk,
	input logic rst,
	input lc3b_pkg::lc3b_word fetch_ir, // instruction from fetch
	input logic hold, // back-pressure from downstream
	input logic branch_enable, // from execute
	output logic fetch_take, // fetch word taken at this edge
	output lc3b_pkg::lc3b_word ex_ir, // id/ex contents
	output logic squash_id // fall-through dropped this cycle
);

	import lc3b_pkg::*;

	hazard_if hz ();

	pipeline_front i_pipeline_front
	(
		.clk(clk),
		.rst(rst),
		.hold(hold),
		.fetch_ir(fetch_ir),
		.fetch_take(fetch_take),
		.hz(hz.pipe)
	);

	bubbler i_bubbler
	(
		.clk(clk),
		.rst(rst),
		.branch_enable(branch_enable),
		.hz(hz.hazard)
	);

	assign ex_ir = hz.id_ex_ir;
	assign squash_id = hz.squash_id;

endmodule

`default_nettype wire

// File: tb/tb_hazard_cases.svh
`ifndef TB_HAZARD_CASES_SVH
`define TB_HAZARD_CASES_SVH

// one row per case, words and expected ex_ir read left to right
typedef struct packed {
	logic [127:0] words; // eight fetch words, first leftmost
	logic be; // branch_enable level for the whole case
	logic [31:0] hold_mask; // bit c holds the pipeline in case cycle c
	logic has_exp; // expected stream below is valid
	logic [191:0] expect_ir; // ex_ir in case cycles 2 to 13
} case_row;

localparam int n_directed = 11;
localparam int exp_len = 12; // words in expect_ir

function automatic case_row make_row
(
	input logic [127:0] words,
	input logic be,
	input logic [31:0] hold_mask,
	input logic has_exp,
	input logic [191:0] expect_ir
);
	return {words, be, hold_mask, has_exp, expect_ir};
endfunction

function automatic case_row directed_row(input int idx);
	case_row row;
	row = '0;
	case (idx)
		0: row = make_row({16'h6440, 16'h1684, 96'h0}, 1'b0, 32'h0, 1'b1,
			{16'h6440, 16'h0000, 16'h1684, 144'h0}); // ldr r2 then add r3,r2,r4
		1: row = make_row({16'h6440, 16'h1662, 96'h0}, 1'b0, 32'h0, 1'b1,
			{16'h6440, 16'h1662, 160'h0}); // imm add, 2:0 is data not a register
		2: row = make_row({16'h6440, 16'h7540, 96'h0}, 1'b0, 32'h0, 1'b1,
			{16'h6440, 16'h0000, 16'h7540, 144'h0}); // str data reg from load
		3: row = make_row({16'h1441, 16'h7540, 96'h0}, 1'b0, 32'h0, 1'b1,
			{16'h1441, 16'h7540, 160'h0}); // add producer, no stall
		4: row = make_row({16'h0e04, 16'h1441, 16'h1641, 80'h0}, 1'b1, 32'h0, 1'b1,
			{16'h0e04, 80'h0, 16'h1641, 80'h0}); // taken br
		5: row = make_row({16'h0e04, 16'h1441, 16'h1641, 80'h0}, 1'b0, 32'h0, 1'b1,
			{16'h0e04, 64'h0, 16'h1441, 16'h1641, 80'h0}); // br falls through
		6: row = make_row({16'he803, 16'h1441, 16'h1641, 80'h0}, 1'b1, 32'h0, 1'b1,
			{16'he803, 64'h0, 16'h1441, 16'h1641, 80'h0}); // lea ignores be
		7: row = make_row({16'hc0c0, 16'h1441, 16'h1641, 80'h0}, 1'b0, 32'h0, 1'b1,
			{16'hc0c0, 80'h0, 16'h1641, 80'h0}); // jmp r3
		8: row = make_row({16'h480a, 16'h1441, 16'h1641, 80'h0}, 1'b1, 32'h0, 1'b1,
			{16'h480a, 80'h0, 16'h1641, 80'h0}); // jsr
		9: row = make_row({16'hf025, 16'h1441, 16'h1641, 80'h0}, 1'b0, 32'h0, 1'b1,
			{16'hf025, 80'h0, 16'h1641, 80'h0}); // trap x25
		10: row = make_row({16'h6440, 16'h1684, 16'h0e04, 16'h1441, 16'h1641, 48'h0},
			1'b1, 32'h0000_2c94, 1'b0, 192'h0); // load-use and br under hold
		default: row = '0;
	endcase
	return row;
endfunction

`endif

// File: tb/tb_lc3b_hazard.sv
`default_nettype none

module tb_lc3b_hazard;

	import lc3b_pkg::*;

	localparam int n_random = 6; // lfsr rows after the directed ones
	localparam int window = 96; // cycles per case with room for eight shadows plus hold
	localparam int hold_span = 32; // hold only in the early cycles of a case
	localparam int resolve_len = 5; // four bubbles then the resolve cycle

	`include "tb_hazard_cases.svh"

	localparam int n_rows = n_directed + n_random;
	localparam int cycle_limit = n_rows * window + 40; // reset and margin

	logic clk;
	logic rst;
	lc3b_word fetch_ir;
	logic hold;
	logic branch_enable;
	logic fetch_take;
	lc3b_word ex_ir;
	logic squash_id;

	int err_count;
	int check_count;
	int cycle_count;
	logic [31:0] lfsr;

	lc3b_word mdl_ifid; // expected if/id
	lc3b_word mdl_idex; // expected id/ex, compared with ex_ir
	lc3b_word mdl_ctl; // control word that opened the shadow
	int mdl_count; // shadow countdown
	logic mdl_be; // latched branch enable
	logic mdl_bubble;
	logic mdl_squash;
	logic mdl_take;
	logic mdl_open; // shadow starts at this edge

	lc3b_hazard_top i_lc3b_hazard_top
	(
		.clk(clk),
		.rst(rst),
		.fetch_ir(fetch_ir),
		.hold(hold),
		.branch_enable(branch_enable),
		.fetch_take(fetch_take),
		.ex_ir(ex_ir),
		.squash_id(squash_id)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit)
		begin
			$display("timeout: run went past %0d cycles without finishing", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic case_row random_row();
		case_row row;
		lc3b_word w;
		logic [2:0] pick;
		logic [31:0] bits;
		int i;
		row = '0;
		for (i = 0; i < 8; i++)
		begin
			bits = take_bits(3);
			pick = bits[2:0];
			case (pick)
				3'd0: w[15:12] = op_add;
				3'd1: w[15:12] = op_and;
				3'd2: w[15:12] = op_not;
				3'd3: w[15:12] = op_ldr;
				3'd4: w[15:12] = op_ldb;
				3'd5: w[15:12] = op_ldi;
				3'd6: w[15:12] = op_str;
				default: w[15:12] = op_br; // may come out as nop
			endcase
			bits = take_bits(12);
			w[11:0] = bits[11:0]; // register fields and immediates
			row.words[127 - 16 * i -: 16] = w;
		end
		bits = take_bits(1);
		row.be = bits[0];
		for (i = 0; i < hold_span; i++)
		begin
			bits = take_bits(2);
			row.hold_mask[i] = (bits[1:0] == 2'b11); // hold about a quarter of cycles
		end
		return row;
	endfunction

	function automatic lc3b_word word_at(input logic [127:0] words, input int i);
		return words[127 - 16 * i -: 16];
	endfunction

	function automatic lc3b_word expected_at(input logic [191:0] stream, input int i);
		return stream[191 - 16 * i -: 16];
	endfunction

	function automatic logic is_load(input lc3b_word w);
		return (w[15:12] == op_ldb) || (w[15:12] == op_ldr) || (w[15:12] == op_ldi);
	endfunction

	function automatic logic is_control(input lc3b_word w);
		return (w[15:12] == op_br) || (w[15:12] == op_jmp) || (w[15:12] == op_jsr) ||
			(w[15:12] == op_trap) || (w[15:12] == op_lea);
	endfunction

	// does w read register r as an operand
	function automatic logic reads_reg(input lc3b_word w, input logic [2:0] r);
		logic hit;
		hit = 1'b0;
		case (w[15:12])
			op_add, op_and: hit = (w[8:6] == r) || (!w[5] && (w[2:0] == r));
			op_not, op_shf, op_ldb, op_ldr, op_ldi, op_jmp: hit = (w[8:6] == r);
			op_stb, op_str, op_sti: hit = (w[8:6] == r) || (w[11:9] == r); // base or data
			op_jsr: hit = !w[11] && (w[8:6] == r); // jsrr form only
			default: hit = 1'b0;
		endcase
		return hit;
	endfunction

	task automatic model_outputs(input logic hold_now);
		mdl_bubble = is_load(mdl_idex) && reads_reg(mdl_ifid, mdl_idex[11:9]);
		mdl_squash = 1'b0;
		mdl_open = 1'b0;
		if (mdl_count == 0)
			mdl_open = (mdl_ifid != nop_word) && is_control(mdl_ifid);
		else if (mdl_count > 1)
			mdl_bubble = 1'b1; // shadow bubbles
		else if (mdl_ctl[15:12] == op_br)
			mdl_squash = mdl_be;
		else
			mdl_squash = (mdl_ctl[15:12] != op_lea);
		mdl_take = !hold_now && !mdl_bubble;
	endtask

	task automatic model_edge(input lc3b_word offer, input logic hold_now, input logic be_now);
		if (mdl_open)
		begin
			mdl_count = resolve_len;
			mdl_ctl = mdl_ifid;
		end
		else if (mdl_count > 0)
			mdl_count = mdl_count - 1; // runs through hold
		if (!hold_now)
		begin
			mdl_be = be_now;
			mdl_idex = (mdl_bubble || mdl_squash) ? nop_word : mdl_ifid;
		end
		if (mdl_take)
			mdl_ifid = offer;
	endtask

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			$display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
			err_count++;
		end
	endtask

	task automatic run_case(input int idx, input case_row row);
		int c;
		int taken;
		int errs_before;
		lc3b_word offer;
		logic hold_now;
		taken = 0;
		errs_before = err_count;
		for (c = 0; c < window; c++)
		begin
			@(posedge clk);
			#1;
			offer = (taken < 8) ? word_at(row.words, taken) : nop_word; // pad with nop
			hold_now = (c < hold_span) ? row.hold_mask[c] : 1'b0;
			fetch_ir = offer;
			hold = hold_now;
			branch_enable = row.be ^ hold_now; // inverted while held and never latched
			model_outputs(hold_now);
			@(negedge clk);
			check_value("ex_ir", mdl_idex, ex_ir);
			check_value("fetch_take", {15'b0, mdl_take}, {15'b0, fetch_take});
			check_value("squash_id", {15'b0, mdl_squash}, {15'b0, squash_id});
			if (row.has_exp && (c >= 2) && (c < 2 + exp_len))
				check_value("ex_ir(table)", expected_at(row.expect_ir, c - 2), ex_ir);
			if (fetch_take)
				taken++; // next word goes out after the edge
			model_edge(offer, hold_now, branch_enable);
		end
		if ((mdl_count != 0) || (mdl_ifid != nop_word) || (mdl_idex != nop_word) || (taken < 8))
		begin
			$display("case %0d did not drain: words still in flight at the end of its window",
				idx);
			err_count++;
		end
		$display("case %0d (%s): %0d errors", idx, (idx < n_directed) ? "directed" : "random",
			err_count - errs_before);
	endtask

	initial
	begin
		int i;
		case_row row;
		clk = 1'b0;
		rst = 1'b1;
		fetch_ir = nop_word;
		hold = 1'b0;
		branch_enable = 1'b0;
		err_count = 0;
		check_count = 0;
		cycle_count = 0;
		lfsr = 32'hb222_8b98;
		mdl_ifid = nop_word; // state right after reset
		mdl_idex = nop_word;
		mdl_ctl = nop_word;
		mdl_count = 0;
		mdl_be = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		for (i = 0; i < n_rows; i++)
		begin
			if (i < n_directed)
				row = directed_row(i);
			else
				row = random_row();
			run_case(i, row);
		end
		$display("%0d cases, %0d checks, %0d errors", n_rows, check_count, err_count);
		if (err_count == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tb
common/lc3b_pkg.sv
common/hazard_if.sv
hazard/dependency_decode.sv
hazard/bubbler.sv
source/pipeline_front.sv
source/lc3b_hazard_top.sv
tb/tb_lc3b_hazard.sv

// File: Bender.yml
package:
  name: lc3b_hazard

sources:
  - files:
      - common/lc3b_pkg.sv
      - common/hazard_if.sv
      - hazard/dependency_decode.sv
      - hazard/bubbler.sv
      - source/pipeline_front.sv
      - source/lc3b_hazard_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_lc3b_hazard.sv
